//--- project.f
+incdir+design
design/mem_geom_pkg.sv
design/mem_port_pkg.sv
design/mem_delay.sv
design/bank_ram.sv
design/mem_lane_align.sv
design/mem_slice_route.sv
design/mem_read_gather.sv
design/mem_main.sv
dv/mem_main_chk.sv
dv/mem_main_tb.sv

//--- Makefile
SIM := obj_dir/Vmem_main_tb

.PHONY: run clean

run: $(SIM)
	$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q "Test completed successfully" sim.log

$(SIM): project.f design/mem_macros.svh $(shell grep -v '^+' project.f)
	verilator --binary --timing --assert --top-module mem_main_tb -f project.f

clean:
	rm -rf obj_dir sim.log

//--- dv/mem_main_tb.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_main_tb
    import mem_geom_pkg::*;
    import mem_port_pkg::*;
();

    localparam int NP = `MEM_NUM_PORTS;
    // Stimulus is near 100 cycles with reset
    localparam int CYCLE_LIMIT = 2000;

    logic        clk;
    logic        rst_n;
    logic        we       [NP];
    logic        re       [NP];
    logic [31:0] addr     [NP];
    line_t       data_in  [NP];
    line_t       data_out [NP];
    logic        rd_rdy   [NP];

    // Request staged for the next edge
    logic        req_we   [NP];
    logic        req_re   [NP];
    logic [31:0] req_addr [NP];
    line_t       req_data [NP];

    word_t       ref_mem [int];
    line_t       exp_q   [NP][$];
    string       name_q  [NP][$];
    logic [13:0] w       [NP];
    int          cycles;

    mem_main u_dut (
        .clk(clk), .rst_n(rst_n), .we(we), .re(re), .addr(addr),
        .data_in(data_in), .data_out(data_out), .rd_rdy(rd_rdy)
    );

    bind mem_main mem_main_chk u_chk (
        .clk(clk), .rst_n(rst_n), .re(re), .rd_rdy(rd_rdy), .data_out(data_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic line_t rand_line();
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k] = $urandom();
        end
        return l;
    endfunction

    // Word k of a line lives at word index wi+k modulo 2**14
    function automatic line_t model_read(slice_idx_t s, logic [13:0] wi);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k] = ref_mem[int'({s, wi + 14'(k)})];
        end
        return l;
    endfunction

    function automatic void model_write(slice_idx_t s, logic [13:0] wi, line_t l);
        for (int k = 0; k < 4; k++) begin
            ref_mem[int'({s, wi + 14'(k)})] = l[k];
        end
    endfunction

    function automatic int pending();
        int n = 0;
        for (int p = 0; p < NP; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    // Idle ports sit on slices 28 to 31 away from the test slices
    task automatic park();
        for (int p = 0; p < NP; p++) begin
            req_we[p]   = 1'b0;
            req_re[p]   = 1'b0;
            req_addr[p] = {11'd0, slice_idx_t'(28 + p), 16'd0};
            req_data[p] = '0;
        end
    endtask

    task automatic stage_write(input int p, input int s, input logic [13:0] wi, input line_t l);
        req_we[p]   = 1'b1;
        req_addr[p] = {11'd0, slice_idx_t'(s), wi, 2'b00};
        req_data[p] = l;
    endtask

    task automatic stage_read(input int p, input int s, input logic [13:0] wi);
        req_re[p]   = 1'b1;
        req_addr[p] = {11'd0, slice_idx_t'(s), wi, 2'b00};
    endtask

    // First port on a slice wins and reads see the contents before this cycle's writes
    task automatic step(input string name);
        int   win [NP];
        logic hit [NP];
        @(posedge clk);
        for (int p = 0; p < NP; p++) begin
            win[p] = -1;
            hit[p] = 1'b0;
            for (int q = 0; q < NP; q++) begin
                if (req_addr[q][20:16] == req_addr[p][20:16]) begin
                    if (win[p] < 0) begin
                        win[p] = q;
                    end
                    hit[p] = hit[p] | req_we[q];
                end
            end
            if (req_re[p]) begin
                exp_q[p].push_back(model_read(req_addr[p][20:16], req_addr[win[p]][15:2]));
                name_q[p].push_back(name);
            end
        end
        for (int p = 0; p < NP; p++) begin
            if (win[p] == p && hit[p]) begin
                model_write(req_addr[p][20:16], req_addr[p][15:2], req_data[p]);
            end
            we[p]      <= req_we[p];
            re[p]      <= req_re[p];
            addr[p]    <= req_addr[p];
            data_in[p] <= req_data[p];
        end
        park();
    endtask

    task automatic check_read(input int p);
        line_t exp;
        string name;
        if (exp_q[p].size() == 0) begin
            stop_with_failure($sformatf("port %0d raised rd_rdy with no read outstanding", p));
        end else begin
            exp  = exp_q[p].pop_front();
            name = name_q[p].pop_front();
            assert (data_out[p] === exp)
                else stop_with_failure($sformatf("Fail: %s port %0d expected %h actual %h",
                                                 name, p, exp, data_out[p]));
        end
    endtask

    task automatic test_aligned();
        repeat (4) begin
            for (int p = 0; p < NP; p++) begin
                w[p] = {12'($urandom()), 2'b00};
                stage_write(p, p, w[p], rand_line());
            end
            step("aligned_write_read");
            for (int p = 0; p < NP; p++) begin
                stage_read(p, p, w[p]);
            end
            step("aligned_write_read");
        end
    endtask

    // Last port straddles the top of the word index range
    task automatic test_unaligned();
        for (int p = 0; p < NP; p++) begin
            w[p] = (p == NP - 1) ? 14'h3ffc : {12'($urandom()), 2'b00};
            stage_write(p, 4 + p, w[p], rand_line());
        end
        step("unaligned_read");
        for (int p = 0; p < NP; p++) begin
            stage_write(p, 4 + p, w[p] + 14'd4, rand_line());
        end
        step("unaligned_read");
        for (int off = 1; off < 4; off++) begin
            for (int p = 0; p < NP; p++) begin
                stage_read(p, 4 + p, w[p] + 14'(off));
            end
            step("unaligned_read");
        end
        repeat (24) begin
            for (int p = 0; p < NP; p++) begin
                stage_read(p, 4 + p, w[p] + 14'($urandom() % 5));
            end
            step("read_burst");
        end
    endtask

    task automatic test_parallel();
        for (int i = 0; i < 4; i++) begin
            for (int p = 0; p < NP; p++) begin
                stage_write(p, 8 + p, 14'(4 * i), rand_line());
            end
            step("parallel_ports");
        end
        repeat (32) begin
            for (int p = 0; p < NP; p++) begin
                if ($urandom() % 2 == 0) begin
                    stage_write(p, 8 + p, 14'($urandom() % 13), rand_line());
                end else begin
                    stage_read(p, 8 + p, 14'($urandom() % 13));
                end
            end
            step("parallel_ports");
        end
    endtask

    task automatic test_conflict();
        stage_write(1, 12, 14'd40, rand_line());
        stage_write(2, 12, 14'd40, rand_line());
        step("slice_conflict");
        stage_read(3, 12, 14'd40);
        step("slice_conflict");
        stage_read(1, 12, 14'd40);
        stage_read(2, 12, 14'd44);
        step("slice_conflict");
        stage_write(0, 13, 14'd0, rand_line());
        step("slice_conflict");
        stage_write(3, 13, 14'd8, rand_line());
        step("slice_conflict");
        // Port 3 loses and keeps its old line
        stage_write(0, 13, 14'd0, rand_line());
        stage_write(3, 13, 14'd8, rand_line());
        step("slice_conflict");
        stage_read(3, 13, 14'd8);
        step("slice_conflict");
        stage_read(0, 13, 14'd0);
        step("slice_conflict");
    endtask

    task automatic test_read_during_write();
        for (int p = 0; p < NP; p++) begin
            w[p] = {12'($urandom()), 2'b00};
            stage_write(p, 16 + p, w[p], rand_line());
        end
        step("read_during_write");
        for (int p = 0; p < NP; p++) begin
            stage_write(p, 16 + p, w[p], rand_line());
            stage_read(p, 16 + p, w[p]);
        end
        step("read_during_write");
        for (int p = 0; p < NP; p++) begin
            stage_read(p, 16 + p, w[p]);
        end
        step("read_during_write");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_with_failure($sformatf("timeout after %0d cycles", CYCLE_LIMIT));
        end
    end

    // Outputs compared half a cycle after the edge that set them
    always @(negedge clk) begin
        assert (u_dut.u_chk.failures == 0)
            else stop_with_failure("bound checker flagged rd_rdy timing or reset state");
        if (rst_n) begin
            for (int p = 0; p < NP; p++) begin
                if (rd_rdy[p]) begin
                    check_read(p);
                end
            end
        end
    end

    initial begin
        void'($urandom(12));
        park();
        rst_n <= 1'b0;
        for (int p = 0; p < NP; p++) begin
            we[p]      <= 1'b0;
            re[p]      <= 1'b0;
            addr[p]    <= req_addr[p];
            data_in[p] <= '0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        test_aligned();
        test_unaligned();
        test_parallel();
        test_conflict();
        test_read_during_write();
        repeat (2) step("idle");
        while (pending() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        if (u_dut.u_chk.failures == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_with_failure("bound checker errors at end of run");
        end
    end

endmodule

//--- dv/mem_main_chk.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_main_chk
    import mem_geom_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  re       [`MEM_NUM_PORTS],
    input logic  rd_rdy   [`MEM_NUM_PORTS],
    input line_t data_out [`MEM_NUM_PORTS]
);

    // Failed assertions so far, watched by the testbench
    int failures = 0;

    for (genvar p = 0; p < `MEM_NUM_PORTS; p++) begin : g_port
        a_rdy_latency: assert property (@(posedge clk) disable iff (!rst_n)
            rd_rdy[p] == $past(re[p], `MEM_READ_LATENCY))
        else begin
            failures++;
            $error("port %0d rd_rdy differs from re %0d cycles earlier", p, `MEM_READ_LATENCY);
        end

        // No pulse without its read
        a_rdy_source: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(rd_rdy[p]) |-> $past(re[p], `MEM_READ_LATENCY))
        else begin
            failures++;
            $error("port %0d rd_rdy rose with no matching re", p);
        end

        a_reset_state: assert property (@(posedge clk)
            !rst_n |-> (!rd_rdy[p] && data_out[p] == '0))
        else begin
            failures++;
            $error("port %0d outputs not cleared during reset", p);
        end
    end

endmodule

//--- design/mem_main.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_main
    import mem_geom_pkg::*;
    import mem_port_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we       [`MEM_NUM_PORTS],
    input  logic        re       [`MEM_NUM_PORTS],
    input  logic [31:0] addr     [`MEM_NUM_PORTS],
    input  line_t       data_in  [`MEM_NUM_PORTS],
    output line_t       data_out [`MEM_NUM_PORTS],
    output logic        rd_rdy   [`MEM_NUM_PORTS]
);

    localparam int NP = `MEM_NUM_PORTS;
    localparam int NS = `MEM_NUM_SLICES;
    localparam int NB = `MEM_BANKS_PER_SLICE;

    // Stage 0
    row_t       row_bank  [NP][NB];
    word_t      word_bank [NP][NB];
    slice_idx_t slice_idx [NP];
    lane_map_t  lane_map  [NP];

    // Stage 1
    logic  slice_we   [NS];
    row_t  slice_row  [NS][NB];
    word_t slice_word [NS][NB];

    // Stage 2
    word_t bank_q [NS][NB];

    // Request fields, named by the stage that consumes them
    slice_idx_t slice_idx_s0 [NP];
    slice_idx_t slice_idx_s2 [NP];
    slice_idx_t slice_idx_s3 [NP];
    lane_map_t  lane_map_s4  [NP];

    mem_lane_align u_align (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (addr),
        .data_in   (data_in),
        .row_bank  (row_bank),
        .word_bank (word_bank),
        .slice_idx (slice_idx),
        .lane_map  (lane_map)
    );

    mem_slice_route u_route (
        .clk        (clk),
        .rst_n      (rst_n),
        .we         (we),
        .slice_idx  (slice_idx_s0),
        .row_bank   (row_bank),
        .word_bank  (word_bank),
        .slice_we   (slice_we),
        .slice_row  (slice_row),
        .slice_word (slice_word)
    );

    for (genvar s = 0; s < NS; s++) begin : g_slice
        for (genvar b = 0; b < NB; b++) begin : g_bank
            bank_ram u_bank (
                .clk  (clk),
                .we   (slice_we[s]),
                .addr (slice_row[s][b]),
                .data (slice_word[s][b]),
                .q    (bank_q[s][b])
            );
        end
    end

    mem_read_gather u_gather (
        .clk          (clk),
        .rst_n        (rst_n),
        .bank_q       (bank_q),
        .slice_idx_d2 (slice_idx_s2),
        .slice_idx_d3 (slice_idx_s3),
        .lane_map_d4  (lane_map_s4),
        .data_out     (data_out)
    );

    for (genvar p = 0; p < NP; p++) begin : g_port
        mem_delay #(.T(logic), .DEPTH(`MEM_READ_LATENCY)) u_rdy_dly (
            .clk(clk), .rst_n(rst_n), .d(re[p]), .q(rd_rdy[p])
        );

        mem_delay #(.T(slice_idx_t), .DEPTH(1)) u_slice_s0 (
            .clk(clk), .rst_n(rst_n), .d(slice_idx[p]), .q(slice_idx_s0[p])
        );

        // Lines up with the bank outputs
        mem_delay #(.T(slice_idx_t), .DEPTH(2)) u_slice_s2 (
            .clk(clk), .rst_n(rst_n), .d(slice_idx_s0[p]), .q(slice_idx_s2[p])
        );

        mem_delay #(.T(slice_idx_t), .DEPTH(1)) u_slice_s3 (
            .clk(clk), .rst_n(rst_n), .d(slice_idx_s2[p]), .q(slice_idx_s3[p])
        );

        // Stage 0 copy plus four more, ready with rd_rdy
        mem_delay #(.T(lane_map_t), .DEPTH(`MEM_READ_LATENCY)) u_lane_s4 (
            .clk(clk), .rst_n(rst_n), .d(lane_map[p]), .q(lane_map_s4[p])
        );
    end

endmodule

//--- design/mem_read_gather.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_read_gather
    import mem_geom_pkg::*;
    import mem_port_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  word_t      bank_q       [`MEM_NUM_SLICES][`MEM_BANKS_PER_SLICE],
    input  slice_idx_t slice_idx_d2 [`MEM_NUM_PORTS],
    input  slice_idx_t slice_idx_d3 [`MEM_NUM_PORTS],
    input  lane_map_t  lane_map_d4  [`MEM_NUM_PORTS],
    output line_t      data_out     [`MEM_NUM_PORTS]
);

    localparam int NP          = `MEM_NUM_PORTS;
    localparam int NS          = `MEM_NUM_SLICES;
    localparam int NB          = `MEM_BANKS_PER_SLICE;
    localparam int GROUP_SIZE  = 4;
    localparam int GROUP_BITS  = $clog2(GROUP_SIZE);
    localparam int NUM_GROUPS  = NS / GROUP_SIZE;
    localparam int SLICE_BITS  = $bits(slice_idx_t);

    // Bank outputs of each slice, still in bank order
    line_t slice_line [NS];

    // Stage 3 and stage 4 registers
    line_t grp_line [NP][NUM_GROUPS];
    line_t sel_line [NP];

    always_comb begin
        for (int s = 0; s < NS; s++) begin
            for (int b = 0; b < NB; b++) begin
                slice_line[s][b] = bank_q[s][b];
            end
        end
    end

    // Stage 3 picks one slice out of every group of four
    always_ff @(posedge clk) begin
        for (int p = 0; p < NP; p++) begin
            for (int g = 0; g < NUM_GROUPS; g++) begin
                grp_line[p][g] <= slice_line[GROUP_SIZE * g +
                                             int'(slice_idx_d2[p][GROUP_BITS-1:0])];
            end
        end
    end

    // Stage 4 picks the group
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NP; p++) begin
                sel_line[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NP; p++) begin
                sel_line[p] <= grp_line[p][slice_idx_d3[p][SLICE_BITS-1:GROUP_BITS]];
            end
        end
    end

    // Stage 5, back from bank order to line order
    always_comb begin
        for (int p = 0; p < NP; p++) begin
            for (int k = 0; k < NB; k++) begin
                data_out[p][k] = sel_line[p][lane_map_d4[p][k]];
            end
        end
    end

endmodule

//--- design/mem_slice_route.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_slice_route
    import mem_geom_pkg::*;
    import mem_port_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       we         [`MEM_NUM_PORTS],
    input  slice_idx_t slice_idx  [`MEM_NUM_PORTS],
    input  row_t       row_bank   [`MEM_NUM_PORTS][`MEM_BANKS_PER_SLICE],
    input  word_t      word_bank  [`MEM_NUM_PORTS][`MEM_BANKS_PER_SLICE],
    output logic       slice_we   [`MEM_NUM_SLICES],
    output row_t       slice_row  [`MEM_NUM_SLICES][`MEM_BANKS_PER_SLICE],
    output word_t      slice_word [`MEM_NUM_SLICES][`MEM_BANKS_PER_SLICE]
);

    localparam int NP = `MEM_NUM_PORTS;
    localparam int NB = `MEM_BANKS_PER_SLICE;

    // Stage 0 copy of the write strobes
    logic we_s0 [NP];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NP; p++) begin
                we_s0[p] <= 1'b0;
            end
        end else begin
            for (int p = 0; p < NP; p++) begin
                we_s0[p] <= we[p];
            end
        end
    end

    for (genvar s = 0; s < `MEM_NUM_SLICES; s++) begin : g_slice
        port_idx_t sel;
        logic      any_we;

        // Scan from the top so the lowest matching port wins
        always_comb begin
            sel    = port_idx_t'(NP - 1);
            any_we = 1'b0;
            for (int p = NP - 1; p >= 0; p--) begin
                if (slice_idx[p] == slice_idx_t'(s)) begin
                    sel    = port_idx_t'(p);
                    any_we = any_we | we_s0[p];
                end
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                slice_we[s] <= 1'b0;
            end else begin
                slice_we[s] <= any_we;
            end
        end

        always_ff @(posedge clk) begin
            for (int b = 0; b < NB; b++) begin
                slice_row[s][b]  <= row_bank[sel][b];
                slice_word[s][b] <= word_bank[sel][b];
            end
        end
    end

endmodule

//--- design/mem_lane_align.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_lane_align
    import mem_geom_pkg::*;
    import mem_port_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] addr      [`MEM_NUM_PORTS],
    input  line_t       data_in   [`MEM_NUM_PORTS],
    output row_t        row_bank  [`MEM_NUM_PORTS][`MEM_BANKS_PER_SLICE],
    output word_t       word_bank [`MEM_NUM_PORTS][`MEM_BANKS_PER_SLICE],
    output slice_idx_t  slice_idx [`MEM_NUM_PORTS],
    output lane_map_t   lane_map  [`MEM_NUM_PORTS]
);

    localparam int NB = `MEM_BANKS_PER_SLICE;

    for (genvar p = 0; p < `MEM_NUM_PORTS; p++) begin : g_port
        logic [13:0] word_idx;
        bank_idx_t   base_bank;
        row_t        row_nxt  [NB];
        word_t       word_nxt [NB];

        assign word_idx     = addr[p][15:2];
        assign base_bank    = word_idx[1:0];
        assign slice_idx[p] = addr[p][20:16];

        // Word k of the line lands in bank base+k
        for (genvar k = 0; k < NB; k++) begin : g_lane
            assign lane_map[p][k] = base_bank + bank_idx_t'(k);
        end

        // For each bank find which word of the line it holds
        always_comb begin
            bank_idx_t   off;
            logic [13:0] idx;
            for (int b = 0; b < NB; b++) begin
                off         = bank_idx_t'(b) - base_bank;
                idx         = word_idx + 14'(off);
                row_nxt[b]  = idx[13:2];
                word_nxt[b] = data_in[p][off];
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int b = 0; b < NB; b++) begin
                    row_bank[p][b]  <= '0;
                    word_bank[p][b] <= '0;
                end
            end else begin
                for (int b = 0; b < NB; b++) begin
                    row_bank[p][b]  <= row_nxt[b];
                    word_bank[p][b] <= word_nxt[b];
                end
            end
        end
    end

endmodule

//--- design/bank_ram.sv
`timescale 1ns/1ps

module bank_ram
    import mem_geom_pkg::*;
(
    input  logic  clk,
    input  logic  we,
    input  row_t  addr,
    input  word_t data,
    output word_t q
);

    word_t mem [2**$bits(row_t)];

    // Read returns the word held before a same-cycle write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        q <= mem[addr];
    end

endmodule

//--- design/mem_delay.sv
`timescale 1ns/1ps

module mem_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  T     d,
    output T     q
);

    T pipe [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign q = pipe[DEPTH-1];

endmodule

//--- design/mem_port_pkg.sv
`include "mem_macros.svh"

package mem_port_pkg;

    typedef logic [$clog2(`MEM_NUM_PORTS)-1:0] port_idx_t;

    // Taken from address bits 20:16
    typedef logic [$clog2(`MEM_NUM_SLICES)-1:0] slice_idx_t;

    // Entry k is the bank holding word k of the line
    typedef mem_geom_pkg::bank_idx_t [`MEM_BANKS_PER_SLICE-1:0] lane_map_t;

endpackage

//--- design/mem_geom_pkg.sv
`include "mem_macros.svh"

package mem_geom_pkg;

    // One memory word
    typedef logic [31:0] word_t;

    // Word 0 sits in the low bits
    typedef word_t [`MEM_BANKS_PER_SLICE-1:0] line_t;

    // Row inside a single bank
    typedef logic [`MEM_ROW_BITS-1:0] row_t;

    // Bank inside a slice
    typedef logic [$clog2(`MEM_BANKS_PER_SLICE)-1:0] bank_idx_t;

endpackage

//--- design/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Requester ports
`define MEM_NUM_PORTS 4

// One slice per hardware thread
`define MEM_NUM_SLICES 32

// Word-interleaved banks inside a slice
`define MEM_BANKS_PER_SLICE 4

// Bank address width, 4096 words per bank
`define MEM_ROW_BITS 12

// Cycles from re to rd_rdy
`define MEM_READ_LATENCY 5

`endif
